// File: hdl/gw_link_pkg.sv
package gw_link_pkg;

  //////////////////////////////////////////////////////////////////////
  // physical link bundle
  //////////////////////////////////////////////////////////////////////

  // serial-side links merged by the concentrator
  localparam int io_link_num_lp = 2;

  // rotation pointer width
  localparam int io_ptr_width_lp = (io_link_num_lp > 1) ? $clog2(io_link_num_lp) : 1;

  // one link word, which is one tunnel flit
  localparam int link_width_lp = 34;

  //////////////////////////////////////////////////////////////////////
  // memory request payload
  //////////////////////////////////////////////////////////////////////

  localparam int mem_addr_width_lp = 8;
  localparam int mem_data_width_lp = 16;
  localparam int mem_words_lp = 1 << mem_addr_width_lp;

  // layout: we at the top, address in bits 23:16, write data in 15:0
  localparam int req_we_bit_lp = 31;
  localparam int req_addr_lsb_lp = 16;

endpackage

// File: hdl/gw_tunnel_pkg.sv
package gw_tunnel_pkg;

  //////////////////////////////////////////////////////////////////////
  // channel tunnel constants
  //////////////////////////////////////////////////////////////////////

  localparam int ct_num_in_lp = 2;
  localparam int ct_chan_width_lp = (ct_num_in_lp > 1) ? $clog2(ct_num_in_lp) : 1;
  localparam int ct_payload_width_lp = 32;

  // receive buffer depth, also the starting credit count
  localparam int ct_remote_credits_lp = 8;
  localparam int ct_ptr_width_lp = $clog2(ct_remote_credits_lp);
  localparam int ct_cnt_width_lp = $clog2(ct_remote_credits_lp + 1);

  // credits go back in batches of 2**lg
  localparam int ct_lg_credit_decimation_lp = 2;
  localparam int ct_pend_width_lp =
    $clog2((ct_remote_credits_lp >> ct_lg_credit_decimation_lp) + 1);

  localparam int ct_credit_width_lp = 8;
  localparam int ct_rsvd_width_lp =
    ct_payload_width_lp - ct_credit_width_lp;

  //////////////////////////////////////////////////////////////////////
  // flit views
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [ct_chan_width_lp-1:0]    chan;
    logic                           credit;
    logic [ct_payload_width_lp-1:0] payload;
  } ct_data_s;

  typedef struct packed {
    logic [ct_chan_width_lp-1:0]   chan;
    logic                          credit;
    logic [ct_rsvd_width_lp-1:0]   rsvd;
    logic [ct_credit_width_lp-1:0] count;
  } ct_credit_s;

  // same link word, decoded by the credit flag
  typedef union packed {
    ct_data_s   data;
    ct_credit_s cred;
  } ct_flit_u;

endpackage

// File: hdl/gw_link_rr_static.sv
`timescale 1ns/1ps

module gw_link_rr_static
  import gw_link_pkg::*;
(
  input  logic                                         mc_clk_i,
  input  logic                                         rst_n_i,

  input  logic [io_link_num_lp-1:0]                    links_v_i,
  input  logic [io_link_num_lp-1:0][link_width_lp-1:0] links_data_i,
  output logic [io_link_num_lp-1:0]                    links_ready_o,

  output logic [io_link_num_lp-1:0]                    links_v_o,
  output logic [io_link_num_lp-1:0][link_width_lp-1:0] links_data_o,
  input  logic [io_link_num_lp-1:0]                    links_ready_i,

  output logic                                         single_v_o,
  output logic [link_width_lp-1:0]                     single_data_o,
  input  logic                                         single_ready_i,

  input  logic                                         single_v_i,
  input  logic [link_width_lp-1:0]                     single_data_i,
  output logic                                         single_ready_o
);

  logic [io_ptr_width_lp-1:0] in_ptr_q;
  logic [io_ptr_width_lp-1:0] out_ptr_q;

  function automatic logic [io_ptr_width_lp-1:0] next_ptr(
    input logic [io_ptr_width_lp-1:0] p
  );
    return (p == io_ptr_width_lp'(io_link_num_lp - 1)) ? '0 : p + 1'b1;
  endfunction

  // inbound: only the link under the pointer may move
  assign single_v_o    = links_v_i[in_ptr_q];
  assign single_data_o = links_data_i[in_ptr_q];

  // outbound: word k goes out on link k mod n
  assign single_ready_o = links_ready_i[out_ptr_q];

  for (genvar i = 0; i < io_link_num_lp; i++) begin : g_lane
    assign links_ready_o[i] = single_ready_i & (in_ptr_q == io_ptr_width_lp'(i));
    assign links_v_o[i]     = single_v_i & (out_ptr_q == io_ptr_width_lp'(i));
    assign links_data_o[i]  = single_data_i;
  end

  always_ff @(posedge mc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_ptr_q  <= '0;
      out_ptr_q <= '0;
    end else begin
      if (single_v_o && single_ready_i) begin
        in_ptr_q <= next_ptr(in_ptr_q);
      end
      if (single_v_i && single_ready_o) begin
        out_ptr_q <= next_ptr(out_ptr_q);
      end
    end
  end

endmodule

// File: hdl/gw_channel_tunnel.sv
`timescale 1ns/1ps

module gw_channel_tunnel
  import gw_link_pkg::*;
  import gw_tunnel_pkg::*;
(
  input  logic                                              mc_clk_i,
  input  logic                                              rst_n_i,

  input  logic                                              multi_v_i,
  input  logic [link_width_lp-1:0]                          multi_data_i,
  output logic                                              multi_ready_o,

  output logic                                              multi_v_o,
  output logic [link_width_lp-1:0]                          multi_data_o,
  input  logic                                              multi_ready_i,

  output logic [ct_num_in_lp-1:0]                           chan_v_o,
  output logic [ct_num_in_lp-1:0][ct_payload_width_lp-1:0]  chan_data_o,
  input  logic [ct_num_in_lp-1:0]                           chan_ready_i,

  input  logic [ct_num_in_lp-1:0]                           chan_v_i,
  input  logic [ct_num_in_lp-1:0][ct_payload_width_lp-1:0]  chan_data_i,
  output logic [ct_num_in_lp-1:0]                           chan_ready_o
);

  ct_flit_u in_flit;
  ct_flit_u out_flit_d;
  ct_flit_u out_flit_q;

  logic out_v_q;
  logic load;
  logic cred_in;
  logic cred_hit;
  logic data_hit;
  logic [ct_chan_width_lp-1:0] cred_chan;
  logic [ct_chan_width_lp-1:0] data_chan;
  logic [ct_chan_width_lp-1:0] rr_q;

  logic [ct_num_in_lp-1:0] fifo_full;
  logic [ct_num_in_lp-1:0] fifo_wr;
  logic [ct_num_in_lp-1:0] pend_nz;
  logic [ct_num_in_lp-1:0] send_nz;
  logic [ct_num_in_lp-1:0] cred_take;
  logic [ct_num_in_lp-1:0] data_take;

  //////////////////////////////////////////////////////////////////////
  // inbound decode
  //////////////////////////////////////////////////////////////////////

  assign in_flit = multi_data_i;

  // credit flits are always absorbed, data waits for buffer room
  assign multi_ready_o = in_flit.data.credit | ~fifo_full[in_flit.data.chan];
  assign cred_in       = multi_v_i & multi_ready_o & in_flit.cred.credit;

  for (genvar c = 0; c < ct_num_in_lp; c++) begin : g_chan
    logic [ct_payload_width_lp-1:0] mem_q [ct_remote_credits_lp];
    logic [ct_ptr_width_lp-1:0] wr_ptr_q;
    logic [ct_ptr_width_lp-1:0] rd_ptr_q;
    logic [ct_cnt_width_lp-1:0] count_q;
    logic [ct_cnt_width_lp-1:0] send_q;
    logic [ct_cnt_width_lp-1:0] send_add;
    logic [ct_lg_credit_decimation_lp-1:0] used_q;
    logic [ct_pend_width_lp-1:0] pend_q;
    logic rd;
    logic batch_done;

    assign fifo_full[c] = (count_q == ct_cnt_width_lp'(ct_remote_credits_lp));
    assign fifo_wr[c]   = multi_v_i & multi_ready_o & ~in_flit.data.credit
                        & (in_flit.data.chan == ct_chan_width_lp'(c));
    assign chan_v_o[c]    = (count_q != '0);
    assign chan_data_o[c] = mem_q[rd_ptr_q];
    assign rd             = chan_v_o[c] & chan_ready_i[c];
    assign batch_done     = rd & (&used_q);

    assign send_add   = (cred_in && in_flit.cred.chan == ct_chan_width_lp'(c)) ?
                        in_flit.cred.count[ct_cnt_width_lp-1:0] : '0;
    assign send_nz[c] = (send_q != '0);
    assign pend_nz[c] = (pend_q != '0);

    always_ff @(posedge mc_clk_i) begin
      if (fifo_wr[c]) begin
        mem_q[wr_ptr_q] <= in_flit.data.payload;
      end
    end

    always_ff @(posedge mc_clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
        used_q   <= '0;
        pend_q   <= '0;
        send_q   <= ct_cnt_width_lp'(ct_remote_credits_lp);
      end else begin
        if (fifo_wr[c]) begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
        if (rd) begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
          used_q   <= used_q + 1'b1;
        end
        count_q <= count_q + ct_cnt_width_lp'(fifo_wr[c]) - ct_cnt_width_lp'(rd);
        pend_q  <= pend_q + ct_pend_width_lp'(batch_done)
                 - ct_pend_width_lp'(cred_take[c]);
        send_q  <= send_q + send_add - ct_cnt_width_lp'(data_take[c]);
      end
    end

    // remote side must respect the credit window
    a_credit_max: assert property (@(posedge mc_clk_i) disable iff (!rst_n_i)
      send_q <= ct_cnt_width_lp'(ct_remote_credits_lp))
      else $error("credit counter above window on channel %0d", c);

    a_fifo_over: assert property (@(posedge mc_clk_i) disable iff (!rst_n_i)
      multi_v_i && !in_flit.data.credit && (in_flit.data.chan == ct_chan_width_lp'(c))
      |-> !fifo_full[c])
      else $error("data flit offered to full receive buffer %0d", c);

    // an empty counter stays empty until credit comes back
    a_data_credit: assert property (@(posedge mc_clk_i) disable iff (!rst_n_i)
      send_q == '0 && send_add == '0 |=> send_q == '0)
      else $error("data flit sent without credit on channel %0d", c);

    // banks hold a response until it is taken
    a_resp_hold: assert property (@(posedge mc_clk_i) disable iff (!rst_n_i)
      chan_v_i[c] && !chan_ready_o[c] |=> chan_v_i[c] && $stable(chan_data_i[c]))
      else $error("response on channel %0d changed before it was taken", c);
  end

  //////////////////////////////////////////////////////////////////////
  // outbound arbitration
  //////////////////////////////////////////////////////////////////////

  assign load = ~out_v_q | multi_ready_i;

  always_comb begin
    int idx;
    cred_hit  = 1'b0;
    data_hit  = 1'b0;
    cred_chan = '0;
    data_chan = '0;
    cred_take = '0;
    data_take = '0;
    // pending credits first, lowest channel wins
    for (int i = 0; i < ct_num_in_lp; i++) begin
      if (!cred_hit && pend_nz[i]) begin
        cred_hit  = 1'b1;
        cred_chan = ct_chan_width_lp'(i);
      end
    end
    // data rotates, starting after the last grant
    for (int i = 1; i <= ct_num_in_lp; i++) begin
      idx = (int'(rr_q) + i) % ct_num_in_lp;
      if (!data_hit && chan_v_i[idx] && send_nz[idx]) begin
        data_hit  = 1'b1;
        data_chan = ct_chan_width_lp'(idx);
      end
    end
    if (load) begin
      if (cred_hit) begin
        cred_take[cred_chan] = 1'b1;
      end else if (data_hit) begin
        data_take[data_chan] = 1'b1;
      end
    end
  end

  assign chan_ready_o = data_take;

  always_comb begin
    if (cred_hit) begin
      out_flit_d.cred = '{chan:   cred_chan,
                          credit: 1'b1,
                          rsvd:   '0,
                          count:  ct_credit_width_lp'(1 << ct_lg_credit_decimation_lp)};
    end else begin
      out_flit_d.data = '{chan:    data_chan,
                          credit:  1'b0,
                          payload: chan_data_i[data_chan]};
    end
  end

  always_ff @(posedge mc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_v_q <= 1'b0;
      rr_q    <= '0;
    end else if (load) begin
      out_v_q <= cred_hit | data_hit;
      if (!cred_hit && data_hit) begin
        rr_q <= data_chan;
      end
    end
  end

  always_ff @(posedge mc_clk_i) begin
    if (load) begin
      out_flit_q <= out_flit_d;
    end
  end

  assign multi_v_o    = out_v_q;
  assign multi_data_o = out_flit_q;

endmodule

// File: hdl/gw_test_mem.sv
`timescale 1ns/1ps

module gw_test_mem
  import gw_link_pkg::*;
  import gw_tunnel_pkg::*;
(
  input  logic                           mc_clk_i,
  input  logic                           rst_n_i,

  input  logic                           req_v_i,
  input  logic [ct_payload_width_lp-1:0] req_data_i,
  output logic                           req_ready_o,

  output logic                           resp_v_o,
  output logic [ct_payload_width_lp-1:0] resp_data_o,
  input  logic                           resp_ready_i
);

  logic [mem_data_width_lp-1:0]   mem_q [mem_words_lp];
  logic [mem_addr_width_lp-1:0]   addr;
  logic [ct_payload_width_lp-1:0] resp_d;
  logic [ct_payload_width_lp-1:0] resp_data_q;
  logic                           resp_v_q;
  logic                           we;
  logic                           req_take;

  assign addr = req_data_i[req_addr_lsb_lp +: mem_addr_width_lp];
  assign we   = req_data_i[req_we_bit_lp];

  // one response slot, freed by the same-cycle take
  assign req_ready_o = ~resp_v_q | resp_ready_i;
  assign req_take    = req_v_i & req_ready_o;

  always_comb begin
    resp_d = '0;
    if (we) begin
      // write ack carries the address, flagged in the top bit
      resp_d[ct_payload_width_lp-1]  = 1'b1;
      resp_d[mem_addr_width_lp-1:0] = addr;
    end else begin
      resp_d[mem_data_width_lp-1:0] = mem_q[addr];
    end
  end

  always_ff @(posedge mc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < mem_words_lp; i++) begin
        mem_q[i] <= '0;
      end
    end else if (req_take && we) begin
      mem_q[addr] <= req_data_i[mem_data_width_lp-1:0];
    end
  end

  always_ff @(posedge mc_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_v_q <= 1'b0;
    end else if (req_take) begin
      resp_v_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_q <= 1'b0;
    end
  end

  always_ff @(posedge mc_clk_i) begin
    if (req_take) begin
      resp_data_q <= resp_d;
    end
  end

  assign resp_v_o    = resp_v_q;
  assign resp_data_o = resp_data_q;

  // a stalled request stays put until the bank takes it
  a_req_hold: assert property (@(posedge mc_clk_i) disable iff (!rst_n_i)
    req_v_i && !req_ready_o |=> req_v_i && $stable(req_data_i))
    else $error("request changed before it was taken");

endmodule

// File: hdl/gw_core_complex.sv
`timescale 1ns/1ps

module gw_core_complex
  import gw_link_pkg::*;
  import gw_tunnel_pkg::*;
(
  input  logic                                         mc_clk_i,
  input  logic                                         rst_n_i,

  input  logic [io_link_num_lp-1:0]                    io_v_i,
  input  logic [io_link_num_lp-1:0][link_width_lp-1:0] io_data_i,
  output logic [io_link_num_lp-1:0]                    io_ready_o,

  output logic [io_link_num_lp-1:0]                    io_v_o,
  output logic [io_link_num_lp-1:0][link_width_lp-1:0] io_data_o,
  input  logic [io_link_num_lp-1:0]                    io_ready_i
);

  // concentrated link, both directions
  logic                     conc_v_lo;
  logic [link_width_lp-1:0] conc_data_lo;
  logic                     tun_ready_lo;
  logic                     tun_v_lo;
  logic [link_width_lp-1:0] tun_data_lo;
  logic                     conc_ready_lo;

  // one request and one response lane per bank
  logic [ct_num_in_lp-1:0]                          req_v;
  logic [ct_num_in_lp-1:0][ct_payload_width_lp-1:0] req_data;
  logic [ct_num_in_lp-1:0]                          req_ready;
  logic [ct_num_in_lp-1:0]                          resp_v;
  logic [ct_num_in_lp-1:0][ct_payload_width_lp-1:0] resp_data;
  logic [ct_num_in_lp-1:0]                          resp_ready;

  gw_link_rr_static io_rr (
    .mc_clk_i      (mc_clk_i),
    .rst_n_i       (rst_n_i),
    .links_v_i     (io_v_i),
    .links_data_i  (io_data_i),
    .links_ready_o (io_ready_o),
    .links_v_o     (io_v_o),
    .links_data_o  (io_data_o),
    .links_ready_i (io_ready_i),
    .single_v_o    (conc_v_lo),
    .single_data_o (conc_data_lo),
    .single_ready_i(tun_ready_lo),
    .single_v_i    (tun_v_lo),
    .single_data_i (tun_data_lo),
    .single_ready_o(conc_ready_lo)
  );

  gw_channel_tunnel tunnel (
    .mc_clk_i     (mc_clk_i),
    .rst_n_i      (rst_n_i),
    .multi_v_i    (conc_v_lo),
    .multi_data_i (conc_data_lo),
    .multi_ready_o(tun_ready_lo),
    .multi_v_o    (tun_v_lo),
    .multi_data_o (tun_data_lo),
    .multi_ready_i(conc_ready_lo),
    .chan_v_o     (req_v),
    .chan_data_o  (req_data),
    .chan_ready_i (req_ready),
    .chan_v_i     (resp_v),
    .chan_data_i  (resp_data),
    .chan_ready_o (resp_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // memory banks, one per channel
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < ct_num_in_lp; i++) begin : g_bank
    gw_test_mem test_mem (
      .mc_clk_i    (mc_clk_i),
      .rst_n_i     (rst_n_i),
      .req_v_i     (req_v[i]),
      .req_data_i  (req_data[i]),
      .req_ready_o (req_ready[i]),
      .resp_v_o    (resp_v[i]),
      .resp_data_o (resp_data[i]),
      .resp_ready_i(resp_ready[i])
    );
  end

endmodule

// File: bench/gw_tb_model.svh
`ifndef GW_TB_MODEL_SVH
`define GW_TB_MODEL_SVH

// credits come back four words at a time
localparam int batch_lp = 1 << ct_lg_credit_decimation_lp;
localparam int timeout_cycles_lp = 2000;

// shadow copy of both banks
logic [mem_data_width_lp-1:0] shadow_mem [ct_num_in_lp][mem_words_lp];

//////////////////////////////////////////////////////////////////////
// reference model
//////////////////////////////////////////////////////////////////////

function automatic logic [ct_payload_width_lp-1:0] make_request(
  input logic                         we,
  input logic [mem_addr_width_lp-1:0] addr,
  input logic [mem_data_width_lp-1:0] wdata
);
  logic [ct_payload_width_lp-1:0] p;
  p = '0;
  p[req_we_bit_lp] = we;
  p[req_addr_lsb_lp +: mem_addr_width_lp] = addr;
  p[mem_data_width_lp-1:0] = wdata;
  return p;
endfunction

// expected bank answer, writes also update the shadow
function automatic logic [ct_payload_width_lp-1:0] expected_response(
  input logic [ct_chan_width_lp-1:0]    chan,
  input logic [ct_payload_width_lp-1:0] req
);
  logic [mem_addr_width_lp-1:0]   addr;
  logic [ct_payload_width_lp-1:0] r;
  addr = req[req_addr_lsb_lp +: mem_addr_width_lp];
  r = '0;
  if (req[req_we_bit_lp]) begin
    shadow_mem[chan][addr] = req[mem_data_width_lp-1:0];
    r[ct_payload_width_lp-1] = 1'b1;
    r[mem_addr_width_lp-1:0] = addr;
  end else begin
    r[mem_data_width_lp-1:0] = shadow_mem[chan][addr];
  end
  return r;
endfunction

function automatic ct_flit_u make_data_flit(
  input logic [ct_chan_width_lp-1:0]    chan,
  input logic [ct_payload_width_lp-1:0] payload
);
  ct_flit_u f;
  f.data.chan    = chan;
  f.data.credit  = 1'b0;
  f.data.payload = payload;
  return f;
endfunction

function automatic ct_flit_u make_credit_flit(
  input logic [ct_chan_width_lp-1:0] chan
);
  ct_flit_u f;
  f.cred.chan   = chan;
  f.cred.credit = 1'b1;
  f.cred.rsvd   = '0;
  f.cred.count  = ct_credit_width_lp'(batch_lp);
  return f;
endfunction

//////////////////////////////////////////////////////////////////////
// compare tasks
//////////////////////////////////////////////////////////////////////

task automatic report_mismatch(
  input string       name,
  input logic [63:0] got,
  input logic [63:0] exp
);
  $display("MISMATCH time=%0t signal=%s got=0x%0h expected=0x%0h", $time, name, got, exp);
  stop_with_failure();
endtask

task automatic check_flit(input ct_flit_u got, input ct_flit_u exp);
  if (got.data.chan !== exp.data.chan) begin
    report_mismatch("io_data_o.chan", 64'(got.data.chan), 64'(exp.data.chan));
  end else if (got.data.credit !== exp.data.credit) begin
    report_mismatch("io_data_o.credit", 64'(got.data.credit), 64'(exp.data.credit));
  end else if (got.data.payload !== exp.data.payload) begin
    report_mismatch("io_data_o.payload", 64'(got.data.payload), 64'(exp.data.payload));
  end
endtask

task automatic check_credit(
  input ct_flit_u                      got,
  input logic [ct_credit_width_lp-1:0] exp_count
);
  if (got.cred.count !== exp_count) begin
    report_mismatch("io_data_o.count", 64'(got.cred.count), 64'(exp_count));
  end else if (got.cred.rsvd !== '0) begin
    report_mismatch("io_data_o.rsvd", 64'(got.cred.rsvd), 64'd0);
  end
endtask

`endif

// File: bench/gw_core_complex_tb.sv
`timescale 1ns/1ps

module gw_core_complex_tb
  import gw_link_pkg::*;
  import gw_tunnel_pkg::*;
();

  logic                                         mc_clk_i = 1'b0;
  logic                                         rst_n_i;
  logic [io_link_num_lp-1:0]                    io_v_i;
  logic [io_link_num_lp-1:0][link_width_lp-1:0] io_data_i;
  logic [io_link_num_lp-1:0]                    io_ready_o;
  logic [io_link_num_lp-1:0]                    io_v_o;
  logic [io_link_num_lp-1:0][link_width_lp-1:0] io_data_o;
  logic [io_link_num_lp-1:0]                    io_ready_i;

  int seed;
  // stream positions on the input and output links
  int in_k;
  int out_k;
  // remote tunnel state, driver side
  int sent     [ct_num_in_lp];
  int cred_ret [ct_num_in_lp];
  // remote tunnel state, monitor side
  int resp_cnt [ct_num_in_lp];
  int cred_rcv [ct_num_in_lp];
  logic [ct_payload_width_lp-1:0] exp_q [ct_num_in_lp][$];

  gw_core_complex dut0 (
    .mc_clk_i  (mc_clk_i),
    .rst_n_i   (rst_n_i),
    .io_v_i    (io_v_i),
    .io_data_i (io_data_i),
    .io_ready_o(io_ready_o),
    .io_v_o    (io_v_o),
    .io_data_o (io_data_o),
    .io_ready_i(io_ready_i)
  );

  always #50 mc_clk_i = ~mc_clk_i;

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic raise_error(input string what);
    $display("ERROR time=%0t %s", $time, what);
    stop_with_failure();
  endtask

  `include "gw_tb_model.svh"

  //////////////////////////////////////////////////////////////////////
  // remote tunnel driver
  //////////////////////////////////////////////////////////////////////

  task automatic idle_cycle();
    @(posedge mc_clk_i);
    #1;
  endtask

  // word k goes on link k mod 2
  task automatic send_word(input ct_flit_u f);
    logic lane;
    int   waited;
    lane = in_k[0];
    waited = 0;
    io_data_i[lane] = f;
    io_v_i[lane] = 1'b1;
    do begin
      @(negedge mc_clk_i);
      waited++;
      if (waited > timeout_cycles_lp) begin
        raise_error($sformatf("input link %0d never became ready", lane));
      end
      if (io_ready_o[~lane]) begin
        raise_error("io_ready_o high on the link out of rotation");
      end
    end while (!io_ready_o[lane]);
    @(posedge mc_clk_i);
    #1;
    io_v_i[lane] = 1'b0;
    in_k++;
  endtask

  task automatic send_credit_returns();
    for (int c = 0; c < ct_num_in_lp; c++) begin
      while (resp_cnt[c] / batch_lp > cred_ret[c]) begin
        cred_ret[c]++;
        send_word(make_credit_flit(ct_chan_width_lp'(c)));
      end
    end
  endtask

  function automatic int credits_left(input logic [ct_chan_width_lp-1:0] chan);
    return ct_remote_credits_lp - sent[chan] + cred_rcv[chan];
  endfunction

  task automatic issue_request(
    input logic [ct_chan_width_lp-1:0]    chan,
    input logic [ct_payload_width_lp-1:0] req
  );
    int waited;
    waited = 0;
    send_credit_returns();
    while (credits_left(chan) <= 0) begin
      waited++;
      if (waited > timeout_cycles_lp) begin
        raise_error($sformatf("no credit came back for channel %0d", chan));
      end
      send_credit_returns();
      idle_cycle();
    end
    exp_q[chan].push_back(expected_response(chan, req));
    sent[chan]++;
    send_word(make_data_flit(chan, req));
  endtask

  task automatic issue_random_request();
    int r;
    r = $random(seed);
    issue_request(r[ct_chan_width_lp-1:0], make_request(r[1], {3'b000, r[6:2]}, r[31:16]));
  endtask

  function automatic bit all_drained();
    bit done;
    done = 1'b1;
    for (int c = 0; c < ct_num_in_lp; c++) begin
      if (resp_cnt[c] != exp_q[c].size()) begin
        done = 1'b0;
      end
      if (cred_rcv[c] != batch_lp * (sent[c] / batch_lp)) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic drain_responses();
    int waited;
    waited = 0;
    while (!all_drained()) begin
      waited++;
      if (waited > timeout_cycles_lp) begin
        raise_error("expected responses or credits never arrived");
      end
      send_credit_returns();
      idle_cycle();
    end
  endtask

  task automatic hold_ready_low(input int gap, input int len);
    repeat (gap) idle_cycle();
    io_ready_i = '0;
    repeat (len) idle_cycle();
    io_ready_i = '1;
  endtask

  //////////////////////////////////////////////////////////////////////
  // output monitor and checker
  //////////////////////////////////////////////////////////////////////

  always @(negedge mc_clk_i) begin : monitor
    logic                        lane;
    logic [ct_chan_width_lp-1:0] c;
    ct_flit_u                    got;
    lane = out_k[0];
    if (rst_n_i) begin
      if (io_v_o[~lane]) begin
        raise_error("io_v_o high on the link out of rotation");
      end else if (io_v_o[lane] && io_ready_i[lane]) begin
        got = io_data_o[lane];
        out_k++;
        if (got.data.credit) begin
          c = got.cred.chan;
          check_credit(got, ct_credit_width_lp'(batch_lp));
          cred_rcv[c] += batch_lp;
          if (cred_rcv[c] > batch_lp * (sent[c] / batch_lp)) begin
            raise_error($sformatf("more credits than consumed words on channel %0d", c));
          end
        end else begin
          c = got.data.chan;
          if (resp_cnt[c] >= exp_q[c].size()) begin
            raise_error($sformatf("response on channel %0d with no request pending", c));
          end else begin
            check_flit(got, make_data_flit(c, exp_q[c][resp_cnt[c]]));
            resp_cnt[c]++;
          end
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin : main
    int r;
    int gap [3];
    int len [3];
    seed = 43;
    rst_n_i = 1'b0;
    io_v_i = '0;
    io_data_i = '0;
    io_ready_i = '1;
    for (int c = 0; c < ct_num_in_lp; c++) begin
      for (int a = 0; a < mem_words_lp; a++) begin
        shadow_mem[c][a] = '0;
      end
    end
    repeat (16) @(posedge mc_clk_i);
    #1;
    rst_n_i = 1'b1;

    // quiet output until the first request
    repeat (20) begin
      @(negedge mc_clk_i);
      if (io_v_o != '0) begin
        raise_error("io_v_o went high after reset with no request sent");
      end
    end
    idle_cycle();

    // same addresses, different data per bank
    for (int i = 0; i < 6; i++) begin
      issue_request(1'b0, make_request(1'b1, 8'(32'h20 + i), 16'(32'h1100 + i)));
      issue_request(1'b1, make_request(1'b1, 8'(32'h20 + i), 16'(32'h2200 + i)));
    end
    for (int i = 0; i < 7; i++) begin
      issue_request(1'b0, make_request(1'b0, 8'(32'h20 + i), 16'h0000));
      issue_request(1'b1, make_request(1'b0, 8'(32'h20 + i), 16'h0000));
    end
    drain_responses();

    // random traffic with output stalls
    for (int k = 0; k < 3; k++) begin
      r = $random(seed);
      gap[k] = 4 + int'(r[4:0]);
      r = $random(seed);
      len[k] = 10 + int'(r[5:0]);
    end
    fork
      begin
        for (int k = 0; k < 60; k++) begin
          issue_random_request();
        end
      end
      begin
        for (int k = 0; k < 3; k++) begin
          hold_ready_low(gap[k], len[k]);
        end
      end
    join
    drain_responses();

    // long mix on both channels
    for (int k = 0; k < 400; k++) begin
      issue_random_request();
    end
    drain_responses();
    repeat (20) idle_cycle();

    $display("NO ERRORS");
    $finish;
  end

endmodule

// File: gw_core_complex.f
+incdir+bench
hdl/gw_link_pkg.sv
hdl/gw_tunnel_pkg.sv
hdl/gw_link_rr_static.sv
hdl/gw_channel_tunnel.sv
hdl/gw_test_mem.sv
hdl/gw_core_complex.sv
bench/gw_core_complex_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= gw_core_complex_tb
FILELIST  ?= gw_core_complex.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
